/* Makefile */
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_gb_bus_fabric
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the simulation prints the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
rtl/gb_bus_pkg.sv
rtl/gb_bus_if.sv
rtl/reset_sequencer.sv
rtl/memory_decoder.sv
rtl/oam_dma.sv
rtl/bus_arbiter.sv
rtl/gb_bus_fabric.sv
testbench/tb_gb_bus_fabric.sv

/* rtl/bus_arbiter.sv */
module bus_arbiter
	import gb_bus_pkg::*;
(
	gb_bus_if.slave    cpu_bus,
	input  region_t    cpu_region,
	gb_bus_if.slave    dma_bus,
	input  region_t    dma_region,
	input  oam_addr_t  oam_index,
	input  logic       dma_active,
	input  addr_t      ppu_adr,
	input  logic       ppu_rd,
	input  logic       ppu_needs_vram,
	input  logic       ppu_needs_oam,
	input  logic       reset_done,
	output vram_addr_t vram_adr,
	output logic       vram_rd,
	output logic       vram_wr,
	output data_t      vram_wdata,
	output oam_addr_t  oam_adr,
	output logic       oam_rd,
	output logic       oam_wr,
	output data_t      oam_wdata,
	output addr_t      ext_adr,
	output logic       ext_rd,
	output logic       ext_wr,
	output data_t      ext_wdata,
	output logic       cs_rom,
	output logic       cs_xram,
	output logic       cs_wram,
	output logic       io_sel,
	input  data_t      vram_rdata,
	input  data_t      oam_rdata,
	input  data_t      ext_rdata,
	input  data_t      io_rdata,
	output data_t      cpu_rdata,
	output data_t      dma_rdata,
	output logic       dma_stall
);

	logic    cpu_ext;
	logic    dma_ext;
	logic    dma_on_vram;
	logic    dma_on_ext;
	region_t ext_region;
	logic    ext_strobe;

	assign cpu_ext = (cpu_region == REGION_ROM) || (cpu_region == REGION_XRAM) ||
		(cpu_region == REGION_WRAM);
	assign dma_ext = (dma_region == REGION_ROM) || (dma_region == REGION_XRAM) ||
		(dma_region == REGION_WRAM);
	assign dma_on_vram = dma_active && (dma_region == REGION_VRAM);
	assign dma_on_ext  = dma_active && dma_ext;

	// ==============================
	// VRAM: PPU, then DMA, then CPU
	always_comb begin
		vram_adr = cpu_bus.adr[12:0];
		vram_rd  = cpu_bus.rd && (cpu_region == REGION_VRAM);
		vram_wr  = cpu_bus.wr && (cpu_region == REGION_VRAM);
		if (ppu_needs_vram) begin
			vram_adr = ppu_adr[12:0];
			vram_rd  = ppu_rd;
			vram_wr  = 1'b0;
		end else if (dma_on_vram) begin
			vram_adr = dma_bus.adr[12:0];
			vram_rd  = dma_bus.rd;
			vram_wr  = 1'b0;
		end
	end

	assign vram_wdata = cpu_bus.wdata;

	// ==============================
	// OAM: PPU, then DMA, then CPU
	always_comb begin
		oam_adr   = cpu_bus.adr[7:0];
		oam_rd    = cpu_bus.rd && (cpu_region == REGION_OAM);
		oam_wr    = cpu_bus.wr && (cpu_region == REGION_OAM);
		oam_wdata = cpu_bus.wdata;
		if (ppu_needs_oam) begin
			oam_adr = ppu_adr[7:0];
			oam_rd  = ppu_rd;
			oam_wr  = 1'b0;
		end else if (dma_active) begin
			oam_adr   = oam_index;
			oam_rd    = 1'b0;
			oam_wr    = dma_bus.wr;
			oam_wdata = dma_bus.wdata;
		end
	end

	// ==============================
	// External bus and chip selects
	always_comb begin
		if (dma_on_ext) begin
			ext_adr    = dma_bus.adr;
			ext_rd     = dma_bus.rd;
			ext_wr     = 1'b0;
			ext_region = dma_region;
			ext_strobe = dma_bus.rd;
		end else begin
			ext_adr    = cpu_bus.adr;
			ext_rd     = cpu_bus.rd && cpu_ext;
			ext_wr     = cpu_bus.wr && cpu_ext && reset_done && !dma_active;
			ext_region = cpu_region;
			ext_strobe = cpu_bus.rd || cpu_bus.wr;
		end
	end

	assign ext_wdata = cpu_bus.wdata;
	assign cs_rom    = ext_strobe && (ext_region == REGION_ROM);
	assign cs_xram   = ext_strobe && (ext_region == REGION_XRAM);
	assign cs_wram   = ext_strobe && (ext_region == REGION_WRAM);
	assign io_sel    = (cpu_bus.rd || cpu_bus.wr) && (cpu_region == REGION_IO);

	// A CPU read that lost its memory sees an open bus
	always_comb begin
		case (cpu_region)
		REGION_VRAM:
			cpu_rdata = (ppu_needs_vram || dma_on_vram) ? OPEN_BUS : vram_rdata;
		REGION_OAM:
			cpu_rdata = (ppu_needs_oam || dma_active) ? OPEN_BUS : oam_rdata;
		REGION_ROM, REGION_XRAM, REGION_WRAM:
			cpu_rdata = dma_on_ext ? OPEN_BUS : ext_rdata;
		REGION_IO:
			cpu_rdata = io_rdata;
		default:
			cpu_rdata = OPEN_BUS;
		endcase
	end

	always_comb begin
		if (dma_region == REGION_VRAM)
			dma_rdata = vram_rdata;
		else if (dma_ext)
			dma_rdata = ext_rdata;
		else
			dma_rdata = OPEN_BUS;
	end

	assign dma_stall = ppu_needs_oam || (dma_on_vram && ppu_needs_vram);

	always_comb begin
		assert (!(vram_wr && ppu_needs_vram))
			else $error("VRAM write while the PPU holds VRAM");
		assert (!(oam_wr && ppu_needs_oam))
			else $error("OAM write while the PPU holds OAM");
	end

endmodule

/* rtl/gb_bus_fabric.sv */
module gb_bus_fabric
	import gb_bus_pkg::*;
#(
	parameter int INIT_TICKS = 16,
	parameter int RUN_TICKS  = 16
) (
	input  logic       gbclk,
	input  logic       rst_n,
	input  logic       gb_on,
	input  addr_t      cpu_adr,
	input  logic       cpu_rd,
	input  logic       cpu_wr,
	input  data_t      cpu_dout,
	output data_t      cpu_din,
	input  addr_t      ppu_adr,
	input  logic       ppu_rd,
	input  logic       ppu_needs_vram,
	input  logic       ppu_needs_oam,
	output vram_addr_t vram_adr,
	output logic       vram_rd,
	output logic       vram_wr,
	output data_t      vram_wdata,
	input  data_t      vram_rdata,
	output oam_addr_t  oam_adr,
	output logic       oam_rd,
	output logic       oam_wr,
	output data_t      oam_wdata,
	input  data_t      oam_rdata,
	output addr_t      ext_adr,
	output logic       ext_rd,
	output logic       ext_wr,
	output data_t      ext_wdata,
	input  data_t      ext_rdata,
	output logic       cs_rom,
	output logic       cs_xram,
	output logic       cs_wram,
	output logic       io_sel,
	input  data_t      io_rdata,
	output logic       gb_reset,
	output logic       dma_active
);

	gb_bus_if cpu_bus ();
	gb_bus_if dma_bus ();

	region_t   cpu_region;
	region_t   dma_region;
	oam_addr_t oam_index;
	data_t     dma_rdata;
	logic      dma_stall;
	logic      reset_done;

	assign cpu_bus.adr   = cpu_adr;
	assign cpu_bus.rd    = cpu_rd;
	assign cpu_bus.wr    = cpu_wr;
	assign cpu_bus.wdata = cpu_dout;

	reset_sequencer #(
		.INIT_TICKS (INIT_TICKS),
		.RUN_TICKS  (RUN_TICKS)
	) reset_seq (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.gb_on      (gb_on),
		.gb_reset   (gb_reset),
		.reset_done (reset_done)
	);

	memory_decoder cpu_map (
		.adr    (cpu_bus.adr),
		.region (cpu_region)
	);

	memory_decoder dma_map (
		.adr    (dma_bus.adr),
		.region (dma_region)
	);

	oam_dma dma (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.gb_reset   (gb_reset),
		.cpu_bus    (cpu_bus.slave),
		.dma_stall  (dma_stall),
		.dma_rdata  (dma_rdata),
		.dma_bus    (dma_bus.master),
		.oam_index  (oam_index),
		.dma_active (dma_active)
	);

	bus_arbiter arbiter (
		.cpu_bus        (cpu_bus.slave),
		.cpu_region     (cpu_region),
		.dma_bus        (dma_bus.slave),
		.dma_region     (dma_region),
		.oam_index      (oam_index),
		.dma_active     (dma_active),
		.ppu_adr        (ppu_adr),
		.ppu_rd         (ppu_rd),
		.ppu_needs_vram (ppu_needs_vram),
		.ppu_needs_oam  (ppu_needs_oam),
		.reset_done     (reset_done),
		.vram_adr       (vram_adr),
		.vram_rd        (vram_rd),
		.vram_wr        (vram_wr),
		.vram_wdata     (vram_wdata),
		.oam_adr        (oam_adr),
		.oam_rd         (oam_rd),
		.oam_wr         (oam_wr),
		.oam_wdata      (oam_wdata),
		.ext_adr        (ext_adr),
		.ext_rd         (ext_rd),
		.ext_wr         (ext_wr),
		.ext_wdata      (ext_wdata),
		.cs_rom         (cs_rom),
		.cs_xram        (cs_xram),
		.cs_wram        (cs_wram),
		.io_sel         (io_sel),
		.vram_rdata     (vram_rdata),
		.oam_rdata      (oam_rdata),
		.ext_rdata      (ext_rdata),
		.io_rdata       (io_rdata),
		.cpu_rdata      (cpu_din),
		.dma_rdata      (dma_rdata),
		.dma_stall      (dma_stall)
	);

endmodule

/* rtl/gb_bus_if.sv */
interface gb_bus_if;

	gb_bus_pkg::addr_t adr;
	logic              rd;
	logic              wr;
	gb_bus_pkg::data_t wdata;

	modport master (
		output adr,
		output rd,
		output wr,
		output wdata
	);

	modport slave (
		input adr,
		input rd,
		input wr,
		input wdata
	);

endinterface

/* rtl/gb_bus_pkg.sv */
package gb_bus_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [12:0] vram_addr_t;
	typedef logic [7:0]  oam_addr_t;
	typedef logic [2:0]  region_t;

	// ==============================
	// Region codes
	localparam region_t REGION_ROM  = 3'd0;
	localparam region_t REGION_VRAM = 3'd1;
	localparam region_t REGION_XRAM = 3'd2;
	localparam region_t REGION_WRAM = 3'd3;
	localparam region_t REGION_OAM  = 3'd4;
	localparam region_t REGION_IO   = 3'd5;
	localparam region_t REGION_NONE = 3'd7;

	// ==============================
	// Memory map, each region ends where the next one starts
	localparam addr_t VRAM_BASE   = 16'h8000;
	localparam addr_t XRAM_BASE   = 16'hA000;
	localparam addr_t WRAM_BASE   = 16'hC000;
	localparam addr_t OAM_BASE    = 16'hFE00;
	localparam addr_t UNUSED_BASE = 16'hFEA0;
	localparam addr_t IO_BASE     = 16'hFF00;

	localparam addr_t DMA_REG_ADDR = 16'hFF46;
	localparam int    OAM_BYTES    = 160;
	localparam data_t OPEN_BUS     = 8'hFF;

	typedef enum logic [1:0] {
		RST_WAIT_CLOCK,
		RST_COUNT,
		RST_DONE
	} rst_state_t;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_t;

endpackage

/* rtl/memory_decoder.sv */
module memory_decoder
	import gb_bus_pkg::*;
(
	input  addr_t   adr,
	output region_t region
);

	// ==============================
	// Address map
	//   0000-7FFF  cartridge ROM
	//   8000-9FFF  VRAM
	//   A000-BFFF  cartridge RAM
	//   C000-FDFF  WRAM and its echo
	//   FE00-FE9F  OAM
	//   FEA0-FEFF  unused
	//   FF00-FFFF  I/O page
	always_comb begin
		if (adr < VRAM_BASE) begin
			region = REGION_ROM;
		end else if (adr < XRAM_BASE) begin
			region = REGION_VRAM;
		end else if (adr < WRAM_BASE) begin
			region = REGION_XRAM;
		end else if (adr < OAM_BASE) begin
			region = REGION_WRAM;
		end else if (adr < UNUSED_BASE) begin
			region = REGION_OAM;
		end else if (adr < IO_BASE) begin
			region = REGION_NONE;
		end else begin
			region = REGION_IO;
		end
	end

endmodule

/* rtl/oam_dma.sv */
module oam_dma
	import gb_bus_pkg::*;
(
	input  logic      gbclk,
	input  logic      rst_n,
	input  logic      gb_reset,
	gb_bus_if.slave   cpu_bus,
	input  logic      dma_stall,
	input  data_t     dma_rdata,
	gb_bus_if.master  dma_bus,
	output oam_addr_t oam_index,
	output logic      dma_active
);

	dma_state_t state;
	data_t      page;
	oam_addr_t  index;
	logic       rd_q;
	data_t      byte_q;
	logic       start;

	assign start = cpu_bus.wr && (cpu_bus.adr == DMA_REG_ADDR);

	// Source page and the byte in flight
	always_ff @(posedge gbclk) begin
		if (start)
			page <= cpu_bus.wdata;
		if (rd_q)
			byte_q <= dma_rdata;
	end

	always_ff @(posedge gbclk) begin
		if (!rst_n || gb_reset) begin
			state <= DMA_IDLE;
			index <= '0;
			rd_q  <= 1'b0;
		end else begin
			rd_q <= dma_bus.rd;
			if (start) begin
				// A new write to the register restarts the copy from byte 0
				state <= DMA_READ;
				index <= '0;
			end else begin
				case (state)
				DMA_READ: begin
					if (!dma_stall)
						state <= DMA_WRITE;
				end
				DMA_WRITE: begin
					if (!dma_stall) begin
						if (index == oam_addr_t'(OAM_BYTES - 1)) begin
							state <= DMA_IDLE;
						end else begin
							index <= index + 1'b1;
							state <= DMA_READ;
						end
					end
				end
				default:
					state <= DMA_IDLE;
				endcase
			end
		end
	end

	assign dma_bus.adr = {page, index};
	assign dma_bus.rd  = (state == DMA_READ) && !dma_stall;
	assign dma_bus.wr  = (state == DMA_WRITE) && !dma_stall;

	// Read data shows up the cycle after the strobe and is held while the write stalls
	assign dma_bus.wdata = rd_q ? dma_rdata : byte_q;

	assign oam_index  = index;
	assign dma_active = (state != DMA_IDLE);

	a_index_step: assert property (@(posedge gbclk) disable iff (!rst_n || gb_reset)
		index != $past(index) && !$past(start) && !$past(gb_reset) |->
		index == $past(index) + 1'b1 && $past(dma_bus.wr))
		else $error("DMA index moved without a completed OAM write");

endmodule

/* rtl/reset_sequencer.sv */
module reset_sequencer
	import gb_bus_pkg::*;
#(
	parameter int INIT_TICKS = 16,
	parameter int RUN_TICKS  = 16
) (
	input  logic gbclk,
	input  logic rst_n,
	input  logic gb_on,
	output logic gb_reset,
	output logic reset_done
);

	localparam int IW = $clog2(INIT_TICKS + 1);
	localparam int RW = $clog2(RUN_TICKS + 1);

	rst_state_t    state;
	logic [IW-1:0] init_cnt;
	logic [RW-1:0] run_cnt;
	logic          done;
	logic          done_next;
	logic          gb_on_r;

	// Second stage only runs once the first stage has finished
	assign done_next = done || (state == RST_DONE && run_cnt == RW'(RUN_TICKS - 1));

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			state      <= RST_WAIT_CLOCK;
			init_cnt   <= '0;
			run_cnt    <= '0;
			done       <= 1'b0;
			gb_on_r    <= 1'b0;
			gb_reset   <= 1'b1;
			reset_done <= 1'b0;
		end else begin
			gb_on_r  <= gb_on;
			done     <= done_next;
			gb_reset <= !(done_next && gb_on);
			if (done_next && gb_on)
				reset_done <= 1'b1;

			// A bouncing power switch keeps the second stage from finishing
			if (gb_on != gb_on_r)
				run_cnt <= '0;
			else if (state == RST_DONE && !done)
				run_cnt <= run_cnt + 1'b1;

			case (state)
			RST_WAIT_CLOCK:
				state <= RST_COUNT;
			RST_COUNT: begin
				init_cnt <= init_cnt + 1'b1;
				if (init_cnt == IW'(INIT_TICKS - 1))
					state <= RST_DONE;
			end
			default:
				state <= RST_DONE;
			endcase
		end
	end

	a_release_after_count: assert property (@(posedge gbclk) disable iff (!rst_n)
		$fell(gb_reset) |-> $past(state) == RST_DONE)
		else $error("gb_reset released before the first stage finished");

endmodule

/* testbench/tb_gb_bus_fabric.sv */
module tb_gb_bus_fabric
	import gb_bus_pkg::*;
();

	logic       gbclk;
	logic       rst_n;
	logic       gb_on;
	addr_t      cpu_adr;
	logic       cpu_rd;
	logic       cpu_wr;
	data_t      cpu_dout;
	data_t      cpu_din;
	addr_t      ppu_adr;
	logic       ppu_rd;
	logic       ppu_needs_vram;
	logic       ppu_needs_oam;
	vram_addr_t vram_adr;
	logic       vram_rd;
	logic       vram_wr;
	data_t      vram_wdata;
	data_t      vram_rdata = '0;
	oam_addr_t  oam_adr;
	logic       oam_rd;
	logic       oam_wr;
	data_t      oam_wdata;
	data_t      oam_rdata = '0;
	addr_t      ext_adr;
	logic       ext_rd;
	logic       ext_wr;
	data_t      ext_wdata;
	data_t      ext_rdata = '0;
	logic       cs_rom;
	logic       cs_xram;
	logic       cs_wram;
	logic       io_sel;
	data_t      io_rdata;
	logic       gb_reset;
	logic       dma_active;

	int         seed;
	int         err_count;
	int         timeout_count;
	int         rel_edges;
	logic       released;
	logic [8:0] dma_count;
	data_t      dma_page;
	logic       quiet;

	gb_bus_fabric #(
		.INIT_TICKS (16),
		.RUN_TICKS  (16)
	) uut (.*);

	initial begin
		gbclk = 1'b0;
		forever #20 gbclk = ~gbclk;
	end

	// ==============================
	// Memory models, data valid the cycle after the read strobe
	always @(posedge gbclk) begin
		if (vram_rd)
			vram_rdata <= {3'b000, vram_adr[12:8]} ^ vram_adr[7:0];
		if (oam_rd)
			oam_rdata <= oam_adr;
		if (ext_rd)
			ext_rdata <= ext_adr[15:8] ^ ext_adr[7:0];
	end

	assign io_rdata = 8'h5A;
	assign quiet    = !dma_active && !ppu_needs_vram && !ppu_needs_oam;

	// Edges since release, first fall of gb_reset and OAM writes of the current copy
	always @(posedge gbclk) begin
		if (!rst_n) begin
			rel_edges <= 0;
			released  <= 1'b0;
			dma_count <= '0;
		end else begin
			rel_edges <= rel_edges + 1;
			if (!gb_reset)
				released <= 1'b1;
			if (cpu_wr && cpu_adr == 16'hFF46)
				dma_count <= '0;
			else if (dma_active && oam_wr)
				dma_count <= dma_count + 1'b1;
		end
	end

	// Bits are rom, xram, wram, io
	function automatic logic [3:0] expect_sel(input addr_t a);
		if (a < 16'h8000)
			return 4'b1000;
		else if (a >= 16'hA000 && a < 16'hC000)
			return 4'b0100;
		else if (a >= 16'hC000 && a < 16'hFE00)
			return 4'b0010;
		else if (a >= 16'hFF00)
			return 4'b0001;
		return 4'b0000;
	endfunction

	function automatic data_t expect_read(input addr_t a);
		if (a >= 16'h8000 && a < 16'hA000)
			return {3'b000, a[12:8]} ^ a[7:0];
		else if (a >= 16'hFE00 && a < 16'hFEA0)
			return a[7:0];
		else if (a >= 16'hFEA0 && a < 16'hFF00)
			return 8'hFF;
		else if (a >= 16'hFF00)
			return 8'h5A;
		return a[15:8] ^ a[7:0];
	endfunction

	function automatic logic in_vram(input addr_t a);
		return a >= 16'h8000 && a < 16'hA000;
	endfunction

	function automatic logic in_oam(input addr_t a);
		return a >= 16'hFE00 && a < 16'hFEA0;
	endfunction

	function automatic addr_t random_addr();
		addr_t a;
		a = addr_t'($random(seed));
		// The DMA register starts a copy and gets its own phase
		if (a == 16'hFF46)
			a = 16'hFF47;
		return a;
	endfunction

	// ==============================
	// Checks
	a_reset_hold: assert property (@(posedge gbclk) disable iff (!rst_n)
		(rel_edges >= 1 && rel_edges <= 32) |-> gb_reset)
		else begin
			err_count++;
			$display("ERROR %0t gb_reset expected 1 got %b", $time, gb_reset);
		end

	a_reset_fall: assert property (@(posedge gbclk) disable iff (!rst_n)
		(rel_edges == 33) |-> !gb_reset)
		else begin
			err_count++;
			$display("ERROR %0t gb_reset expected 0 got %b", $time, gb_reset);
		end

	a_reset_follow: assert property (@(posedge gbclk) disable iff (!rst_n)
		(rel_edges >= 34) |-> gb_reset == !$past(gb_on))
		else begin
			err_count++;
			$display("ERROR %0t gb_reset expected %b got %b", $time, !$past(gb_on), gb_reset);
		end

	a_selects: assert property (@(posedge gbclk) disable iff (!rst_n)
		!dma_active |-> {cs_rom, cs_xram, cs_wram, io_sel} ==
		((cpu_rd || cpu_wr) ? expect_sel(cpu_adr) : 4'b0000))
		else begin
			err_count++;
			$display("ERROR %0t cs_rom/cs_xram/cs_wram/io_sel expected %b got %b", $time,
				expect_sel(cpu_adr), {cs_rom, cs_xram, cs_wram, io_sel});
		end

	a_cpu_path: assert property (@(posedge gbclk) disable iff (!rst_n)
		quiet |-> ext_adr == cpu_adr && ext_wdata == cpu_dout && vram_wdata == cpu_dout &&
		vram_rd == (cpu_rd && in_vram(cpu_adr)) && oam_rd == (cpu_rd && in_oam(cpu_adr)) &&
		ext_rd == (cpu_rd && |(expect_sel(cpu_adr) & 4'b1110)))
		else begin
			err_count++;
			$display("ERROR %0t ext_adr/ext_wdata/vram_wdata expected %h/%h/%h got %h/%h/%h",
				$time, cpu_adr, cpu_dout, cpu_dout, ext_adr, ext_wdata, vram_wdata);
			$display("ERROR %0t vram_rd/oam_rd/ext_rd expected %b/%b/%b got %b/%b/%b", $time,
				cpu_rd && in_vram(cpu_adr), cpu_rd && in_oam(cpu_adr),
				cpu_rd && |(expect_sel(cpu_adr) & 4'b1110), vram_rd, oam_rd, ext_rd);
		end

	a_read_data: assert property (@(posedge gbclk) disable iff (!rst_n)
		$past(cpu_rd && quiet) && quiet && cpu_adr == $past(cpu_adr) |->
		cpu_din == expect_read(cpu_adr))
		else begin
			err_count++;
			$display("ERROR %0t cpu_din expected %h got %h", $time, expect_read(cpu_adr), cpu_din);
		end

	a_ext_wr_early: assert property (@(posedge gbclk) disable iff (!rst_n)
		gb_reset && !released |-> !ext_wr)
		else begin
			err_count++;
			$display("ERROR %0t ext_wr expected 0 got %b", $time, ext_wr);
		end

	a_ext_wr: assert property (@(posedge gbclk) disable iff (!rst_n)
		released |-> ext_wr == (cpu_wr && !dma_active && |(expect_sel(cpu_adr) & 4'b1110)))
		else begin
			err_count++;
			$display("ERROR %0t ext_wr expected %b got %b", $time,
				cpu_wr && !dma_active && |(expect_sel(cpu_adr) & 4'b1110), ext_wr);
		end

	a_ppu_vram: assert property (@(posedge gbclk) disable iff (!rst_n)
		ppu_needs_vram |-> vram_adr == ppu_adr[12:0] && !vram_wr)
		else begin
			err_count++;
			$display("ERROR %0t vram_adr/vram_wr expected %h/0 got %h/%b", $time,
				ppu_adr[12:0], vram_adr, vram_wr);
		end

	a_ppu_oam: assert property (@(posedge gbclk) disable iff (!rst_n)
		ppu_needs_oam |-> oam_adr == ppu_adr[7:0] && !oam_wr)
		else begin
			err_count++;
			$display("ERROR %0t oam_adr/oam_wr expected %h/0 got %h/%b", $time,
				ppu_adr[7:0], oam_adr, oam_wr);
		end

	a_vram_blocked: assert property (@(posedge gbclk) disable iff (!rst_n)
		ppu_needs_vram && in_vram(cpu_adr) |-> cpu_din == 8'hFF)
		else begin
			err_count++;
			$display("ERROR %0t cpu_din expected ff got %h", $time, cpu_din);
		end

	a_oam_blocked: assert property (@(posedge gbclk) disable iff (!rst_n)
		(ppu_needs_oam || dma_active) && in_oam(cpu_adr) |-> cpu_din == 8'hFF)
		else begin
			err_count++;
			$display("ERROR %0t cpu_din expected ff got %h", $time, cpu_din);
		end

	a_dma_start: assert property (@(posedge gbclk) disable iff (!rst_n)
		$past(cpu_wr && cpu_adr == 16'hFF46 && !gb_reset) |-> dma_active)
		else begin
			err_count++;
			$display("ERROR %0t dma_active expected 1 got %b", $time, dma_active);
		end

	a_dma_order: assert property (@(posedge gbclk) disable iff (!rst_n)
		dma_active && oam_wr |-> oam_adr == dma_count[7:0] &&
		oam_wdata == (dma_page ^ dma_count[7:0]))
		else begin
			err_count++;
			$display("ERROR %0t oam_adr/oam_wdata expected %h/%h got %h/%h", $time,
				dma_count[7:0], dma_page ^ dma_count[7:0], oam_adr, oam_wdata);
		end

	a_dma_length: assert property (@(posedge gbclk) disable iff (!rst_n)
		$fell(dma_active) |-> dma_count == 9'd160)
		else begin
			err_count++;
			$display("ERROR %0t OAM write count expected 160 got %0d", $time, dma_count);
		end

	// ==============================
	// Stimulus
	task automatic cpu_read(input addr_t a);
		@(negedge gbclk);
		cpu_adr = a;
		cpu_rd  = 1'b1;
		@(negedge gbclk);
		cpu_rd = 1'b0;
	endtask

	task automatic cpu_write(input addr_t a, input data_t d);
		@(negedge gbclk);
		cpu_adr  = a;
		cpu_dout = d;
		cpu_wr   = 1'b1;
		@(negedge gbclk);
		cpu_wr = 1'b0;
	endtask

	task automatic finish_run();
		$display("Checks failed: %0d, timeouts: %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic wait_reset_low();
		int n;
		n = 0;
		while (gb_reset && n < 200) begin
			@(negedge gbclk);
			n++;
		end
		if (gb_reset) begin
			$display("Timed out waiting for gb_reset to fall");
			timeout_count++;
			finish_run();
		end
	endtask

	// The CPU pokes at OAM while the copy runs, optionally with the PPU stalling it
	task automatic run_dma(input data_t page, input logic ppu_busy);
		int          n;
		logic [31:0] r;
		addr_t       a;
		dma_page = page;
		cpu_write(16'hFF46, page);
		n = 0;
		while (dma_active && n < 2000) begin
			r = $random(seed);
			ppu_needs_oam = ppu_busy && r[0];
			ppu_rd        = r[1];
			ppu_adr       = addr_t'(r[31:16]);
			a = 16'hFE00 | addr_t'(r[15:8] % 8'd160);
			if (r[2])
				cpu_write(a, r[23:16]);
			else
				cpu_read(a);
			n++;
		end
		ppu_needs_oam = 1'b0;
		ppu_rd        = 1'b0;
		if (dma_active) begin
			$display("Timed out waiting for the OAM DMA copy to finish");
			timeout_count++;
			finish_run();
		end
	endtask

	initial begin
		logic [31:0] r;
		seed           = 32'h46;
		err_count      = 0;
		timeout_count  = 0;
		dma_page       = '0;
		rst_n          = 1'b0;
		gb_on          = 1'b1;
		cpu_adr        = '0;
		cpu_rd         = 1'b0;
		cpu_wr         = 1'b0;
		cpu_dout       = '0;
		ppu_adr        = '0;
		ppu_rd         = 1'b0;
		ppu_needs_vram = 1'b0;
		ppu_needs_oam  = 1'b0;
		repeat (5) @(negedge gbclk);
		rst_n = 1'b1;

		// WRAM writes while the system is still held in reset
		repeat (8) begin
			r = $random(seed);
			cpu_write({3'b110, r[12:0]}, r[23:16]);
		end
		wait_reset_low();

		repeat (200) begin
			r = $random(seed);
			if (r[0])
				cpu_write(random_addr(), r[15:8]);
			else
				cpu_read(random_addr());
		end

		repeat (120) begin
			r = $random(seed);
			ppu_needs_vram = r[0];
			ppu_needs_oam  = r[1];
			ppu_rd         = r[2];
			ppu_adr        = addr_t'(r[31:16]);
			case (r[4:3])
			2'd0: cpu_read({3'b100, r[15:3]});
			2'd1: cpu_write({3'b100, r[15:3]}, r[23:16]);
			2'd2: cpu_read(16'hFE00 | addr_t'(r[15:8] % 8'd160));
			default: cpu_write(16'hFE00 | addr_t'(r[15:8] % 8'd160), r[23:16]);
			endcase
		end
		ppu_needs_vram = 1'b0;
		ppu_needs_oam  = 1'b0;
		ppu_rd         = 1'b0;

		// Power switch off, back on, then a one-cycle glitch
		@(negedge gbclk);
		gb_on = 1'b0;
		repeat (6) @(negedge gbclk);
		gb_on = 1'b1;
		@(negedge gbclk);
		gb_on = 1'b0;
		@(negedge gbclk);
		gb_on = 1'b1;
		wait_reset_low();

		run_dma(8'hC1, 1'b0);
		run_dma(8'h3C, 1'b1);
		repeat (4) cpu_read(random_addr());
		finish_run();
	end

endmodule
